/* fetch_frontend.f */
verilog/fetch_pkg.sv
verilog/fetch_bundle_if.sv
verilog/sync_fifo.sv
verilog/fetch_pc_gen.sv
verilog/predecode_lane.sv
verilog/fetch_bundle_pack.sv
verilog/fetch_frontend.sv
verif/fetch_frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_frontend_tb \
    -f fetch_frontend.f -o fetch_frontend_sim \
    && ./obj_dir/fetch_frontend_sim | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* verif/fetch_frontend_tb.sv */
`timescale 1ns/1ps

module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam int          NUM_TESTS  = 5;
    localparam logic [31:0] SEED       = 32'h8f9ef229;

    logic                clk;
    logic                rst = 1'b1;
    logic                commit_redirect = 1'b0;
    pc_t                 commit_pc = '0;
    logic                imem_req_valid;
    logic                imem_req_ready = 1'b0;
    pc_t                 imem_addr;
    logic                imem_resp_valid = 1'b0;
    logic [SS-1:0][31:0] imem_resp_data = '0;
    logic                out_valid;
    logic                out_ready = 1'b1;
    pc_t                 out_pc;
    logic [SS-1:0][31:0] out_instr;
    logic [SS-1:0]       out_lane_valid;
    logic                out_pred_taken;
    pc_t                 out_pred_target;

    // sparse program, everything else comes from the fill pattern
    logic [31:0]   imap [pc_t];
    // intended offset and kind of every placed control transfer
    int            off_map [pc_t];
    logic          jal_map [pc_t];
    // accepted requests waiting for their response cycle
    pc_t           pend_addr [$];
    int            pend_due [$];
    pc_t           out_log [$];
    logic          acc_seen = 1'b0;
    pc_t           acc_addr = '0;
    int            cyc = 0;
    int            last_due = 0;
    int            due;
    logic          bp_mode = 1'b0;
    int            stretch = 0;
    int            low_run = 0;
    logic          stall_seen = 1'b0;
    pc_t           exp_pc = RESET_PC;
    fetch_bundle_t exp_b;
    int            n_out = 0;
    int            redirect_idx = 0;
    int            n_checks = 0;
    int            n_errors = 0;

    fetch_frontend fetch_frontend_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // unmapped words are ADDI x1, x0, imm with imm folded from the whole address
    function automatic logic [31:0] mem_word(pc_t a);
        logic [11:0] imm;
        imm = a[13:2] ^ a[25:14] ^ {6'b0, a[31:26]};
        if (imap.exists(a)) begin
            return imap[a];
        end
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // jal x1, offset
    function automatic logic [31:0] jal_word(logic [31:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, OPC_JAL};
    endfunction

    // beq x1, x2, offset
    function automatic logic [31:0] branch_word(logic [31:0] o);
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], OPC_BRANCH};
    endfunction

    task automatic clear_program();
        imap.delete();
        off_map.delete();
        jal_map.delete();
    endtask

    // jal when jal is set, otherwise a conditional branch
    task automatic place_transfer(pc_t a, logic jal, int off);
        imap[a]    = jal ? jal_word(off) : branch_word(off);
        off_map[a] = off;
        jal_map[a] = jal;
    endtask

    // expected bundle at base, first predicted transfer closes it
    function automatic fetch_bundle_t ref_bundle(pc_t base);
        fetch_bundle_t b;
        pc_t           a;
        logic          hit;
        b             = '0;
        b.pc          = base;
        b.pred_target = base + 32'(4 * SS);
        for (int i = 0; i < SS; i++) begin
            a          = base + 32'(4 * i);
            b.instr[i] = mem_word(a);
            if (!b.pred_taken) begin
                b.lane_valid[i] = 1'b1;
                // jal always, conditional branch only when the offset is negative
                hit = off_map.exists(a) && (jal_map[a] || off_map[a] < 0);
                if (hit) begin
                    b.pred_taken  = 1'b1;
                    b.pred_target = a + off_map[a];
                end
            end
        end
        return b;
    endfunction

    function automatic logic seen(pc_t a);
        foreach (out_log[i]) begin
            if (out_log[i] == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic compare_value(string name, logic [31:0] exp_v, logic [31:0] act_v);
        n_checks++;
        assert (act_v === exp_v) else begin
            n_errors++;
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic require_true(logic cond, string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("error at time %0t: %s", $time, what);
        end
    endtask

    // memory model, random ready and in-order answers 1 to 4 cycles later
    always @(negedge clk) begin
        acc_seen = !rst && imem_req_valid && imem_req_ready;
        acc_addr = imem_addr;
    end

    always @(posedge clk) begin
        if (rst) begin
            pend_addr.delete();
            pend_due.delete();
            last_due = 0;
            imem_req_ready  <= 1'b0;
            imem_resp_valid <= 1'b0;
        end else begin
            if (acc_seen) begin
                due = cyc + int'($urandom_range(1, 4));
                // keep responses in request order
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(acc_addr);
                pend_due.push_back(due);
            end
            if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
                for (int i = 0; i < SS; i++) begin
                    imem_resp_data[i] <= mem_word(pend_addr[0] + 32'(4 * i));
                end
                imem_resp_valid <= 1'b1;
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end else begin
                imem_resp_valid <= 1'b0;
            end
            imem_req_ready <= ($urandom_range(0, 3) != 0);
        end
        cyc++;
    end

    // back end, long stalls with short bursts when back-pressure is on
    always @(posedge clk) begin
        if (!bp_mode) begin
            out_ready <= 1'b1;
        end else if (stretch == 0) begin
            out_ready <= !out_ready;
            stretch = out_ready ? int'($urandom_range(20, 60)) : int'($urandom_range(1, 8));
        end else begin
            stretch--;
        end
    end

    // output monitor against the reference path
    always @(negedge clk) begin
        if (rst) begin
            exp_pc = RESET_PC;
            n_out  = 0;
            out_log.delete();
            low_run    = 0;
            stall_seen = 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                exp_b = ref_bundle(exp_pc);
                compare_value("out_pc", exp_b.pc, out_pc);
                for (int i = 0; i < SS; i++) begin
                    compare_value($sformatf("out_instr[%0d]", i), exp_b.instr[i], out_instr[i]);
                end
                compare_value("out_lane_valid", 32'(exp_b.lane_valid), 32'(out_lane_valid));
                compare_value("out_pred_taken", 32'(exp_b.pred_taken), 32'(out_pred_taken));
                compare_value("out_pred_target", exp_b.pred_target, out_pred_target);
                out_log.push_back(out_pc);
                n_out++;
                exp_pc = exp_b.pred_target;
            end
            // redirect lands at the coming edge, after this transfer
            if (commit_redirect) begin
                exp_pc       = commit_pc;
                redirect_idx = n_out;
            end
            low_run = out_ready ? 0 : low_run + 1;
            if (low_run > 16 && !imem_req_valid) begin
                stall_seen = 1'b1;
            end
        end
    end

    // program may be changed once this returns
    task automatic hold_reset();
        @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic release_reset();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("out_valid", 32'(0), 32'(out_valid));
        while (!imem_req_valid) @(negedge clk);
        compare_value("imem_addr", RESET_PC, imem_addr);
    endtask

    task automatic wait_bundles(int n);
        while (n_out < n) @(negedge clk);
    endtask

    task automatic sequential_fetch();
        hold_reset();
        clear_program();
        release_reset();
        wait_bundles(8);
        for (int i = 0; i < 8; i++) begin
            compare_value("out_pc", RESET_PC + 32'(8 * i), out_log[i]);
        end
    endtask

    task automatic jal_redirect();
        hold_reset();
        clear_program();
        // jal in lane 0 of the third bundle
        place_transfer(RESET_PC + 32'h10, 1'b1, 32'h100);
        release_reset();
        wait_bundles(6);
        require_true(seen(RESET_PC + 32'h110), "jal target bundle never fetched");
        require_true(!seen(RESET_PC + 32'h18), "fall-through bundle after jal was delivered");
    endtask

    task automatic branch_prediction();
        hold_reset();
        clear_program();
        // forward branch in lane 0, backward branch in lane 1
        place_transfer(RESET_PC + 32'h08, 1'b0, 32'h40);
        place_transfer(RESET_PC + 32'h14, 1'b0, -16);
        release_reset();
        wait_bundles(12);
        require_true(!seen(RESET_PC + 32'h48), "forward branch was predicted taken");
        require_true(seen(RESET_PC + 32'h04), "backward branch target never fetched");
        require_true(!seen(RESET_PC + 32'h18), "fall-through after backward branch delivered");
    endtask

    task automatic commit_flush();
        hold_reset();
        clear_program();
        place_transfer(RESET_PC + 32'h20c, 1'b1, 32'h40);
        release_reset();
        wait_bundles(3);
        // redirect while responses of the old path are still outstanding
        while (pend_addr.size() < 2) @(negedge clk);
        @(posedge clk);
        commit_redirect <= 1'b1;
        commit_pc       <= RESET_PC + 32'h200;
        @(posedge clk);
        commit_redirect <= 1'b0;
        wait_bundles(n_out + 6);
        compare_value("out_pc", RESET_PC + 32'h200, out_log[redirect_idx]);
    endtask

    task automatic back_pressure();
        hold_reset();
        clear_program();
        place_transfer(RESET_PC + 32'h1c, 1'b1, 32'h80);
        place_transfer(RESET_PC + 32'ha4, 1'b0, -136);
        bp_mode = 1'b1;
        release_reset();
        wait_bundles(30);
        require_true(stall_seen, "imem_req_valid never dropped while the queue was full");
        bp_mode = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        sequential_fetch();
        jal_redirect();
        branch_prediction();
        commit_flush();
        back_pressure();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, 2000 cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        n_errors++;
        $display("timeout: tests still running after %0d cycles", NUM_TESTS * 2000);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog/fetch_bundle_if.sv */
`timescale 1ns/1ps

// one memory bundle on its way from the pc generator to predecode and packing
interface fetch_bundle_if;
    import fetch_pkg::*;

    // response belongs to the current epoch
    logic                valid;
    // address of word 0
    pc_t                 pc;
    // raw words, lane i at pc + 4*i
    logic [SS-1:0][31:0] instr;

    // pc generator side
    modport source (
        output valid,
        output pc,
        output instr
    );

    // predecode lanes and packer, no ready since credits guarantee room
    modport sink (
        input valid,
        input pc,
        input instr
    );

endinterface

/* verilog/fetch_bundle_pack.sv */
`timescale 1ns/1ps

module fetch_bundle_pack (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               commit_redirect,
    fetch_bundle_if.sink                       bundle,
    input  fetch_pkg::lane_pred_t              preds [fetch_pkg::SS],
    output logic                               pd_redirect,
    output fetch_pkg::pc_t                     pd_target,
    output logic [fetch_pkg::IQ_CNT_W-1:0]     free_slots,
    output logic                               out_valid,
    input  logic                               out_ready,
    output fetch_pkg::fetch_bundle_t           out_bundle
);
    import fetch_pkg::*;

    logic            any_taken;
    pc_t             taken_target;
    logic [SS-1:0]   lane_valid;
    fetch_bundle_t   entry;
    logic            iq_push;
    logic            iq_pop;
    logic            iq_empty;

    // scan lanes in program order, first taken one ends the bundle
    always_comb begin
        any_taken    = 1'b0;
        taken_target = '0;
        lane_valid   = '1;
        for (int i = 0; i < SS; i++) begin
            if (any_taken) begin
                // shadow of an earlier taken transfer
                lane_valid[i] = 1'b0;
            end else if (preds[i].taken) begin
                any_taken    = 1'b1;
                taken_target = preds[i].target;
            end
        end
    end

    // steer the pc generator toward the predicted target
    assign pd_redirect = bundle.valid && any_taken;
    assign pd_target   = taken_target;

    assign entry.pc          = bundle.pc;
    assign entry.instr       = bundle.instr;
    assign entry.lane_valid  = lane_valid;
    assign entry.pred_taken  = any_taken;
    // next fetch pc either way, sequential when nothing is taken
    assign entry.pred_target = any_taken ? taken_target : bundle.pc + 32'(4 * SS);

    // bundle arriving with a commit redirect belongs to the old path
    assign iq_push   = bundle.valid && !commit_redirect;
    assign iq_pop    = out_valid && out_ready;
    assign out_valid = !iq_empty;

    // instruction queue, credits from free_slots keep it from overflowing
    // a full queue reports zero free slots
    sync_fifo #(
        .payload_t (fetch_bundle_t),
        .DEPTH     (IQ_DEPTH)
    ) iq_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (commit_redirect),
        .push       (iq_push),
        .push_data  (entry),
        .pop        (iq_pop),
        .pop_data   (out_bundle),
        .empty      (iq_empty),
        .full       (),
        .free_count (free_slots)
    );

endmodule

/* verilog/fetch_frontend.sv */
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              commit_redirect,
    input  fetch_pkg::pc_t                    commit_pc,
    output logic                              imem_req_valid,
    input  logic                              imem_req_ready,
    output fetch_pkg::pc_t                    imem_addr,
    input  logic                              imem_resp_valid,
    input  logic [fetch_pkg::SS-1:0][31:0]    imem_resp_data,
    output logic                              out_valid,
    input  logic                              out_ready,
    output fetch_pkg::pc_t                    out_pc,
    output logic [fetch_pkg::SS-1:0][31:0]    out_instr,
    output logic [fetch_pkg::SS-1:0]          out_lane_valid,
    output logic                              out_pred_taken,
    output fetch_pkg::pc_t                    out_pred_target
);
    import fetch_pkg::*;

    fetch_bundle_if          bundle_if ();
    lane_pred_t              preds [SS];
    logic                    pd_redirect;
    pc_t                     pd_target;
    logic [IQ_CNT_W-1:0]     free_slots;
    fetch_bundle_t           out_bundle;

    fetch_pc_gen pc_gen_i (
        .clk             (clk),
        .rst             (rst),
        .commit_redirect (commit_redirect),
        .commit_pc       (commit_pc),
        .pd_redirect     (pd_redirect),
        .pd_target       (pd_target),
        .free_slots      (free_slots),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .bundle          (bundle_if)
    );

    // one predecoder per word of the bundle
    for (genvar i = 0; i < SS; i++) begin : g_lane
        predecode_lane #(
            .LANE (i)
        ) lane_i (
            .bundle (bundle_if),
            .pred   (preds[i])
        );
    end

    fetch_bundle_pack pack_i (
        .clk             (clk),
        .rst             (rst),
        .commit_redirect (commit_redirect),
        .bundle          (bundle_if),
        .preds           (preds),
        .pd_redirect     (pd_redirect),
        .pd_target       (pd_target),
        .free_slots      (free_slots),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_bundle      (out_bundle)
    );

    // queue head split onto plain ports
    assign out_pc          = out_bundle.pc;
    assign out_instr       = out_bundle.instr;
    assign out_lane_valid  = out_bundle.lane_valid;
    assign out_pred_taken  = out_bundle.pred_taken;
    assign out_pred_target = out_bundle.pred_target;

endmodule

/* verilog/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                commit_redirect,
    input  fetch_pkg::pc_t                      commit_pc,
    input  logic                                pd_redirect,
    input  fetch_pkg::pc_t                      pd_target,
    input  logic [fetch_pkg::IQ_CNT_W-1:0]      free_slots,
    output logic                                imem_req_valid,
    input  logic                                imem_req_ready,
    output fetch_pkg::pc_t                      imem_addr,
    input  logic                                imem_resp_valid,
    input  logic [fetch_pkg::SS-1:0][31:0]      imem_resp_data,
    fetch_bundle_if.source                      bundle
);
    import fetch_pkg::*;

    pc_t                    pc_q;
    logic                   epoch_q;
    logic                   req_fire;
    logic                   credit_ok;
    req_tag_t               push_tag;
    req_tag_t               resp_tag;
    logic                   tag_empty;
    logic                   tag_full;
    logic [INF_CNT_W-1:0]   tag_free;
    logic [INF_CNT_W-1:0]   inflight;

    // outstanding requests are exactly the tags still waiting for data
    assign inflight = INF_CNT_W'(MAX_INFLIGHT) - tag_free;

    // only ask memory when every outstanding response has a queue slot
    assign credit_ok = (32'(inflight) < 32'(free_slots)) && !tag_full;

    assign imem_req_valid = credit_ok;
    // a redirect may replace the pending address before it is taken
    assign imem_addr      = pc_q;
    assign req_fire       = imem_req_valid && imem_req_ready;

    // tag carries the epoch the request was issued in
    assign push_tag.pc    = pc_q;
    assign push_tag.epoch = epoch_q;

    // in-order tags for requests memory has accepted
    sync_fifo #(
        .payload_t (req_tag_t),
        .DEPTH     (MAX_INFLIGHT)
    ) tag_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (1'b0),
        .push       (req_fire),
        .push_data  (push_tag),
        .pop        (imem_resp_valid),
        .pop_data   (resp_tag),
        .empty      (tag_empty),
        .full       (tag_full),
        .free_count (tag_free)
    );

    // every response retires one tag
    // stale epoch means the path was redirected after issue, drop it
    assign bundle.valid = imem_resp_valid && !tag_empty && (resp_tag.epoch == epoch_q);
    assign bundle.pc    = resp_tag.pc;
    assign bundle.instr = imem_resp_data;

    // pc priority: commit, then predecode, then sequential on accept
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= RESET_PC;
            epoch_q <= 1'b0;
        end else if (commit_redirect) begin
            pc_q    <= commit_pc;
            epoch_q <= ~epoch_q;
        end else if (pd_redirect) begin
            // request fired this cycle still holds the old epoch and is dropped
            pc_q    <= pd_target;
            epoch_q <= ~epoch_q;
        end else if (req_fire) begin
            pc_q    <= pc_q + 32'(4 * SS);
        end
    end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // instruction words per fetch bundle
    localparam int SS = 2;

    // first fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h6000_0000;

    // instruction queue entries and outstanding memory requests
    localparam int IQ_DEPTH     = 4;
    localparam int MAX_INFLIGHT = 4;

    // counter widths, sized to hold the full depth
    localparam int IQ_CNT_W  = $clog2(IQ_DEPTH + 1);
    localparam int INF_CNT_W = $clog2(MAX_INFLIGHT + 1);

    // rv32i opcodes seen by predecode
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef logic [31:0] pc_t;

    // one outstanding request, epoch marks the fetch path it belongs to
    typedef struct packed {
        pc_t  pc;
        logic epoch;
    } req_tag_t;

    // queued bundle as seen by the back end
    typedef struct packed {
        pc_t                  pc;
        logic [SS-1:0][31:0]  instr;
        logic [SS-1:0]        lane_valid;
        logic                 pred_taken;
        pc_t                  pred_target;
    } fetch_bundle_t;

    // per lane predecode result
    typedef struct packed {
        logic taken;
        pc_t  target;
    } lane_pred_t;

endpackage

/* verilog/predecode_lane.sv */
`timescale 1ns/1ps

module predecode_lane #(
    parameter int LANE = 0
) (
    fetch_bundle_if.sink         bundle,
    output fetch_pkg::lane_pred_t pred
);
    import fetch_pkg::*;

    logic [31:0] word;
    logic [6:0]  opcode;
    pc_t         lane_pc;
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    logic        is_jal;
    logic        is_branch;
    logic [31:0] imm;

    assign word    = bundle.instr[LANE];
    assign opcode  = word[6:0];
    // word LANE sits LANE slots past the bundle base
    assign lane_pc = bundle.pc + 32'(4 * LANE);

    // J-type offset, bit 0 always zero
    assign j_imm = {
        {12{word[31]}},
        word[19:12],
        word[20],
        word[30:21],
        1'b0
    };

    // B-type offset
    assign b_imm = {
        {20{word[31]}},
        word[7],
        word[30:25],
        word[11:8],
        1'b0
    };

    assign is_jal    = (opcode == OPC_JAL);
    assign is_branch = (opcode == OPC_BRANCH);

    assign imm = is_jal ? j_imm : b_imm;

    // jal always taken
    // conditional branch taken only when it jumps backwards
    assign pred.taken  = is_jal || (is_branch && b_imm[31]);
    assign pred.target = lane_pc + imm;

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   free_count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    // requests against a full or empty buffer are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(DEPTH));
    assign free_count = CNT_W'(DEPTH) - count;
    // head entry stays put until popped
    assign pop_data   = mem[rd_ptr];

    // control state, flush empties the buffer in one cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy unchanged
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule
